/* Makefile */
TOP := tb_haar_feature_fetch

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) \
		-f haar_feature_fetch.f --Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

/* haar_feature_fetch.f */
hw/haar_pkg.sv
hw/feature_sequencer.sv
hw/rect_addr_gen.sv
hw/weight_rom.sv
hw/rects_mem.sv
hw/haar_feature_fetch.sv
testbench/tb_haar_feature_fetch.sv

/* hw/feature_sequencer.sv */
`default_nettype none

module feature_sequencer #(
   parameter int feature_num = 8,
   localparam int idx_w = (feature_num > 1) ? $clog2(feature_num) : 1
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          start,
   input  logic                          feature_done,
   output logic                          busy,
   output logic                          feat_valid,
   input  logic [haar_pkg::rect_num-1:0] feat_ready,
   output logic [idx_w-1:0]              feat_index
);

   typedef enum logic [1:0] {
      st_idle,
      st_issue,
      st_wait
   } state_t;

   localparam logic [idx_w-1:0] last_index = idx_w'(feature_num - 1);

   state_t state;

   assign busy       = (state != st_idle);
   assign feat_valid = (state == st_issue);

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= st_idle;
         feat_index <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (start) begin   // Start while busy never reaches here.
                  state      <= st_issue;
                  feat_index <= '0;
               end
            end
            st_issue: begin
               if (&feat_ready) begin   // Every unit takes the index together.
                  state <= st_wait;
               end
            end
            st_wait: begin
               if (feature_done) begin
                  if (feat_index == last_index) begin
                     state <= st_idle;
                  end else begin
                     state      <= st_issue;
                     feat_index <= feat_index + 1'b1;
                  end
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

/* hw/haar_feature_fetch.sv */
`default_nettype none

module haar_feature_fetch #(
   parameter int feature_num = 8,
   localparam int idx_w = (feature_num > 1) ? $clog2(feature_num) : 1
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                start,
   output logic                busy,

   output logic                addr_valid,
   input  logic                addr_ready,
   output haar_pkg::pix_addr_t addr_data,
   output haar_pkg::eot_t      addr_eot,

   output logic                weight_valid,
   input  logic                weight_ready,
   output haar_pkg::weight_t   weight
);

   import haar_pkg::*;

   logic                feat_valid;
   logic [idx_w-1:0]    feat_index;
   logic [rect_num-1:0] feat_ready;
   logic [rect_num-1:0] geom_ready;
   logic [rect_num-1:0] wrom_ready;
   logic                feature_done;

   logic [rect_num-1:0] corner_valid;
   logic [rect_num-1:0] corner_ready;
   pix_addr_t           corner_addr [rect_num];
   eot_t                corner_eot [rect_num];

   logic [rect_num-1:0] wt_valid;
   logic [rect_num-1:0] wt_ready;
   weight_t             wt_data [rect_num];

   feature_sequencer #(
      .feature_num (feature_num)
   ) u_seq (
      .clk          (clk),
      .rst          (rst),
      .start        (start),
      .feature_done (feature_done),
      .busy         (busy),
      .feat_valid   (feat_valid),
      .feat_ready   (feat_ready),
      .feat_index   (feat_index)
   );

   for (genvar r = 0; r < rect_num; r++) begin : g_rect
      rect_addr_gen #(
         .feature_num (feature_num),
         .rect_idx    (r)
      ) u_addr (
         .clk          (clk),
         .rst          (rst),
         .feat_valid   (feat_valid),
         .feat_ready   (geom_ready[r]),
         .feat_index   (feat_index),
         .corner_valid (corner_valid[r]),
         .corner_ready (corner_ready[r]),
         .corner_addr  (corner_addr[r]),
         .corner_eot   (corner_eot[r])
      );

      weight_rom #(
         .feature_num (feature_num),
         .rect_idx    (r)
      ) u_wt (
         .clk        (clk),
         .rst        (rst),
         .feat_valid (feat_valid),
         .feat_ready (wrom_ready[r]),
         .feat_index (feat_index),
         .wt_valid   (wt_valid[r]),
         .wt_ready   (wt_ready[r]),
         .wt_data    (wt_data[r])
      );

      assign feat_ready[r] = geom_ready[r] & wrom_ready[r];   // One answer per rectangle.
   end

   rects_mem u_drain (
      .clk          (clk),
      .rst          (rst),
      .corner_valid (corner_valid),
      .corner_ready (corner_ready),
      .corner_addr  (corner_addr),
      .corner_eot   (corner_eot),
      .wt_valid     (wt_valid),
      .wt_ready     (wt_ready),
      .wt_data      (wt_data),
      .addr_valid   (addr_valid),
      .addr_ready   (addr_ready),
      .addr_data    (addr_data),
      .addr_eot     (addr_eot),
      .weight_valid (weight_valid),
      .weight_ready (weight_ready),
      .weight       (weight),
      .feature_done (feature_done)
   );

endmodule

`default_nettype wire

/* hw/haar_pkg.sv */
`default_nettype none

package haar_pkg;

   localparam int win_size = 25;
   localparam int int_side = win_size + 1;   // Integral image has one extra row and column.
   localparam int rect_num = 3;

   typedef logic [4:0] coord_t;

   // Layout of one line of rect_geom.hex.
   typedef struct packed {
      coord_t x;
      coord_t y;
      coord_t w;
      coord_t h;
   } geom_t;

   typedef logic [9:0] pix_addr_t;

   typedef logic signed [2:0] weight_t;

   typedef logic [1:0] eot_t;

   localparam eot_t eot_none = 2'b00;
   localparam eot_t eot_rect = 2'b01;   // Last corner of a rectangle.
   localparam eot_t eot_last = 2'b11;   // Last corner of the whole walk.

endpackage

`default_nettype wire

/* hw/rect_addr_gen.sv */
`default_nettype none

module rect_addr_gen #(
   parameter int feature_num = 8,
   parameter int rect_idx    = 0,
   localparam int idx_w = (feature_num > 1) ? $clog2(feature_num) : 1
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                feat_valid,
   output logic                feat_ready,
   input  logic [idx_w-1:0]    feat_index,
   output logic                corner_valid,
   input  logic                corner_ready,
   output haar_pkg::pix_addr_t corner_addr,
   output haar_pkg::eot_t      corner_eot
);

   import haar_pkg::*;

   localparam logic [idx_w-1:0] last_index = idx_w'(feature_num - 1);

   geom_t      file_img [rect_num * feature_num];
   geom_t      rom [feature_num];
   geom_t      geom;
   logic       last_feat;
   logic [1:0] corner;
   logic       accept;
   logic       fire;
   coord_t     row;
   coord_t     col;

   // The file is rectangle-major; keep only this rectangle's third.
   initial begin
      $readmemh("hw/rect_geom.hex", file_img);
      for (int i = 0; i < feature_num; i++) begin
         rom[i] = file_img[rect_idx * feature_num + i];
      end
   end

   assign feat_ready = ~corner_valid;
   assign accept     = feat_valid & feat_ready;
   assign fire       = corner_valid & corner_ready;

   // Registered ROM read, so valid shows up one cycle after acceptance.
   always_ff @(posedge clk) begin
      if (accept) begin
         geom      <= rom[feat_index];
         last_feat <= (feat_index == last_index);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         corner_valid <= 1'b0;
         corner       <= '0;
      end else if (accept) begin
         corner_valid <= 1'b1;
         corner       <= '0;
      end else if (fire) begin
         corner <= corner + 1'b1;   // Wraps back to 0 after corner 3.
         if (corner == 2'd3) begin
            corner_valid <= 1'b0;
         end
      end
   end

   // Corner order (x,y), (x+w,y), (x,y+h), (x+w,y+h).
   assign col = corner[0] ? coord_t'(geom.x + geom.w) : geom.x;
   assign row = corner[1] ? coord_t'(geom.y + geom.h) : geom.y;

   assign corner_addr = pix_addr_t'(row) * pix_addr_t'(int_side) + pix_addr_t'(col);

   always_comb begin
      if (corner != 2'd3) begin
         corner_eot = eot_none;
      end else if (last_feat && rect_idx == rect_num - 1) begin
         corner_eot = eot_last;
      end else begin
         corner_eot = eot_rect;
      end
   end

endmodule

`default_nettype wire

/* hw/rect_geom.hex */
// One rectangle per line as x, y, w, h packed 5 bits each (x in the top bits).
// Rectangle 0 of features 0 to 7 first, then rectangle 1, then rectangle 2.
00030C
010D54
021206
00A2C9
030992
01A844
040118
0295EF
00330C
060D54
022A06
00C6C8
031586
04B8C4
000118
0528A5
031986
038CB4
024206
0608C6
032D86
07B8C4
080118
000339

/* hw/rect_weight.hex */
// One signed 3-bit weight per line, two's complement (7 is -1, 6 is -2).
// Rectangle 0 of features 0 to 7 first, then rectangle 1, then rectangle 2.
7
7
6
7
7
7
6
7
2
2
3
3
2
2
3
2
1
0
1
2
1
3
1
1

/* hw/rects_mem.sv */
`default_nettype none

module rects_mem (
   input  logic                          clk,
   input  logic                          rst,

   input  logic [haar_pkg::rect_num-1:0] corner_valid,
   output logic [haar_pkg::rect_num-1:0] corner_ready,
   input  haar_pkg::pix_addr_t           corner_addr [haar_pkg::rect_num],
   input  haar_pkg::eot_t                corner_eot [haar_pkg::rect_num],

   input  logic [haar_pkg::rect_num-1:0] wt_valid,
   output logic [haar_pkg::rect_num-1:0] wt_ready,
   input  haar_pkg::weight_t             wt_data [haar_pkg::rect_num],

   output logic                          addr_valid,
   input  logic                          addr_ready,
   output haar_pkg::pix_addr_t           addr_data,
   output haar_pkg::eot_t                addr_eot,

   output logic                          weight_valid,
   input  logic                          weight_ready,
   output haar_pkg::weight_t             weight,

   output logic                          feature_done
);

   import haar_pkg::*;

   localparam int ptr_w = $clog2(rect_num);
   localparam logic [ptr_w-1:0] last_rect = ptr_w'(rect_num - 1);

   logic [ptr_w-1:0] ptr;
   logic             corner_done;
   logic             wt_done;
   logic             corner_last;
   logic             wt_fire;
   logic             rect_complete;

   assign addr_valid   = corner_valid[ptr];
   assign addr_data    = corner_addr[ptr];
   assign addr_eot     = corner_eot[ptr];
   assign weight_valid = wt_valid[ptr];
   assign weight       = wt_data[ptr];

   // Only the selected unit sees the outside ready signals.
   always_comb begin
      corner_ready      = '0;
      wt_ready          = '0;
      corner_ready[ptr] = addr_ready;
      wt_ready[ptr]     = weight_ready;
   end

   assign corner_last = addr_valid & addr_ready & addr_eot[0];
   assign wt_fire     = weight_valid & weight_ready;

   // Both halves of the rectangle have gone, now or earlier.
   assign rect_complete = (corner_done | corner_last) & (wt_done | wt_fire);
   assign feature_done  = rect_complete & (ptr == last_rect);

   always_ff @(posedge clk) begin
      if (rst) begin
         ptr         <= '0;
         corner_done <= 1'b0;
         wt_done     <= 1'b0;
      end else if (rect_complete) begin
         ptr         <= (ptr == last_rect) ? '0 : ptr + 1'b1;
         corner_done <= 1'b0;
         wt_done     <= 1'b0;
      end else begin
         if (corner_last) begin
            corner_done <= 1'b1;
         end
         if (wt_fire) begin
            wt_done <= 1'b1;   // Weight went first, wait for the corners.
         end
      end
   end

endmodule

`default_nettype wire

/* hw/weight_rom.sv */
`default_nettype none

module weight_rom #(
   parameter int feature_num = 8,
   parameter int rect_idx    = 0,
   localparam int idx_w = (feature_num > 1) ? $clog2(feature_num) : 1
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              feat_valid,
   output logic              feat_ready,
   input  logic [idx_w-1:0]  feat_index,
   output logic              wt_valid,
   input  logic              wt_ready,
   output haar_pkg::weight_t wt_data
);

   import haar_pkg::*;

   weight_t file_img [rect_num * feature_num];
   weight_t rom [feature_num];
   logic    accept;

   initial begin
      $readmemh("hw/rect_weight.hex", file_img);
      for (int i = 0; i < feature_num; i++) begin
         rom[i] = file_img[rect_idx * feature_num + i];
      end
   end

   assign feat_ready = ~wt_valid;   // Output register must be empty.
   assign accept     = feat_valid & feat_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         wt_valid <= 1'b0;
      end else if (accept) begin
         wt_valid <= 1'b1;
      end else if (wt_ready) begin
         wt_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         wt_data <= rom[feat_index];
      end
   end

endmodule

`default_nettype wire

/* testbench/tb_haar_feature_fetch.sv */
`default_nettype none

module tb_haar_feature_fetch;

   timeunit 1ns;
   timeprecision 1ps;

   import haar_pkg::*;

   localparam int feature_num = 8;
   localparam int beat_max    = feature_num * rect_num * 4;
   localparam int wt_max      = feature_num * rect_num;
   localparam int run_limit   = 5000;   // Cycles allowed for one run.
   localparam int n_runs      = 4;

   logic      clk;
   logic      rst;
   logic      start;
   logic      busy;
   logic      addr_valid;
   logic      addr_ready;
   pix_addr_t addr_data;
   eot_t      addr_eot;
   logic      weight_valid;
   logic      weight_ready;
   weight_t   weight;

   geom_t     geom_img [rect_num * feature_num];
   weight_t   wt_img [rect_num * feature_num];
   pix_addr_t exp_addr [beat_max];
   eot_t      exp_eot [beat_max];
   weight_t   exp_weight [wt_max];

   // Run name, ready probability in percent, features expected, extra start pulses.
   string run_name [n_runs] = '{"full_rate", "light_stall", "heavy_stall", "start_while_busy"};
   int    ready_pct [n_runs] = '{100, 70, 30, 60};
   int    feat_count [n_runs] = '{8, 8, 8, 8};
   bit    poke_start [n_runs] = '{0, 0, 0, 1};

   logic [31:0] rng_state = 32'h02f11dd8;
   int          addr_errors = 0;
   int          eot_errors = 0;
   int          weight_errors = 0;
   int          other_errors = 0;
   int          timeouts = 0;

   haar_feature_fetch #(
      .feature_num (feature_num)
   ) UUT (
      .clk          (clk),
      .rst          (rst),
      .start        (start),
      .busy         (busy),
      .addr_valid   (addr_valid),
      .addr_ready   (addr_ready),
      .addr_data    (addr_data),
      .addr_eot     (addr_eot),
      .weight_valid (weight_valid),
      .weight_ready (weight_ready),
      .weight       (weight)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Separate draws keep the two readies independent.
   task automatic drive_readies(input int pct);
      rng_state    = xorshift32(rng_state);
      addr_ready   = (rng_state % 100) < pct;
      rng_state    = xorshift32(rng_state);
      weight_ready = (rng_state % 100) < pct;
   endtask

   task automatic build_expected();
      geom_t g;
      int    col;
      int    row;
      int    beat;
      $readmemh("hw/rect_geom.hex", geom_img);
      $readmemh("hw/rect_weight.hex", wt_img);
      for (int f = 0; f < feature_num; f++) begin
         for (int r = 0; r < rect_num; r++) begin
            g = geom_img[r * feature_num + f];   // Files are rectangle-major.
            exp_weight[f * rect_num + r] = wt_img[r * feature_num + f];
            for (int c = 0; c < 4; c++) begin
               beat = (f * rect_num + r) * 4 + c;
               col  = int'(g.x);
               row  = int'(g.y);
               if (c == 1 || c == 3) begin
                  col = col + int'(g.w);
               end
               if (c == 2 || c == 3) begin
                  row = row + int'(g.h);
               end
               exp_addr[beat] = pix_addr_t'(row * int_side + col);
               if (c != 3) begin
                  exp_eot[beat] = 2'b00;
               end else if (beat == beat_max - 1) begin
                  exp_eot[beat] = 2'b11;
               end else begin
                  exp_eot[beat] = 2'b01;
               end
            end
         end
      end
   endtask

   task automatic check_addr(input string name, input pix_addr_t exp, input pix_addr_t act);
      if (act !== exp) begin
         addr_errors++;
         $display("Error %s: address expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic check_eot(input string name, input eot_t exp, input eot_t act);
      if (act !== exp) begin
         eot_errors++;
         $display("Error %s: eot expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_weight(input string name, input weight_t exp, input weight_t act);
      if (act !== exp) begin
         weight_errors++;
         $display("Error %s: weight expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         other_errors++;
         $display("Error %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic apply_run(input int r);
      int    n_beats;
      int    n_wts;
      int    a_cnt;
      int    w_cnt;
      int    cycles;
      string tag;
      n_beats = feat_count[r] * rect_num * 4;
      n_wts   = feat_count[r] * rect_num;
      a_cnt   = 0;
      w_cnt   = 0;
      cycles  = 0;
      @(posedge clk);
      #5;
      start = 1'b1;
      drive_readies(ready_pct[r]);
      @(posedge clk);
      #5;
      start = 1'b0;
      drive_readies(ready_pct[r]);
      @(negedge clk);
      check_flag({run_name[r], " busy after start"}, 1'b1, busy);
      // Handshakes are sampled at the falling edge.
      while (a_cnt < n_beats || w_cnt < n_wts) begin
         if (cycles == run_limit) begin
            $display("Timeout: run %s stalled after %0d address and %0d weight beats",
                     run_name[r], a_cnt, w_cnt);
            timeouts++;
            return;
         end
         if (addr_valid && addr_ready) begin
            tag = $sformatf("%s beat %0d", run_name[r], a_cnt);
            if (a_cnt < n_beats) begin
               check_addr(tag, exp_addr[a_cnt], addr_data);
               check_eot(tag, exp_eot[a_cnt], addr_eot);
            end else begin
               other_errors++;
               $display("Error %s: an address beat came after the end of the walk", tag);
            end
            a_cnt++;
         end
         if (weight_valid && weight_ready) begin
            tag = $sformatf("%s weight %0d", run_name[r], w_cnt);
            if (w_cnt < n_wts) begin
               check_weight(tag, exp_weight[w_cnt], weight);
            end else begin
               other_errors++;
               $display("Error %s: a weight came after the end of the walk", tag);
            end
            w_cnt++;
         end
         @(posedge clk);
         #5;
         start = poke_start[r] && (cycles % 9 == 4) && (a_cnt < n_beats - 8);
         drive_readies(ready_pct[r]);
         @(negedge clk);
         cycles++;
      end
      // Busy drops on the edge that carries the last of both transfers.
      check_flag({run_name[r], " busy after final beat"}, 1'b0, busy);
      check_flag({run_name[r], " addr_valid when idle"}, 1'b0, addr_valid);
      check_flag({run_name[r], " weight_valid when idle"}, 1'b0, weight_valid);
   endtask

   initial begin
      rst          = 1'b1;
      start        = 1'b0;
      addr_ready   = 1'b0;
      weight_ready = 1'b0;
      build_expected();
      repeat (16) @(posedge clk);
      #5;
      rst = 1'b0;
      @(negedge clk);
      check_flag("reset addr_valid", 1'b0, addr_valid);
      check_flag("reset weight_valid", 1'b0, weight_valid);
      check_flag("reset busy", 1'b0, busy);
      for (int r = 0; r < n_runs; r++) begin
         if (timeouts == 0) begin
            apply_run(r);
         end
      end
      $display("Errors: address %0d, eot %0d, weight %0d, other %0d, timeouts %0d",
               addr_errors, eot_errors, weight_errors, other_errors, timeouts);
      if (addr_errors + eot_errors + weight_errors + other_errors + timeouts == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire
